//--- source/stripe_pkg.sv
package stripe_pkg;

  // Geometry of the striped memory
  localparam int NUM_BANKS  = 2;
  localparam int ADDR_WIDTH = 10;
  localparam int DATA_WIDTH = 16;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Byte offset inside a word, then the bank field, then the row
  localparam int BYTE_BITS = $clog2(STRB_WIDTH);
  localparam int SEL_BITS  = $clog2(NUM_BANKS);
  localparam int ROW_BITS  = ADDR_WIDTH - BYTE_BITS - SEL_BITS;

  // Word count held by one bank
  localparam int BANK_DEPTH = 2 ** ROW_BITS;

  // The only response this memory ever returns
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Width of the bresp and rresp fields
  localparam int RESP_WIDTH = 2;

endpackage

//--- source/stripe_if.sv
// Write path between the writer and one bank
interface stripe_wr_if;
  import stripe_pkg::*;

  logic [ROW_BITS-1:0]   awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [RESP_WIDTH-1:0] bresp;
  logic                  bvalid;
  logic                  bready;

  modport router (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport bank (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );

  modport mon (
    input awaddr, awvalid, awready, wdata, wstrb, wvalid, wready,
    input bresp, bvalid, bready
  );

endinterface

// Read path between the reader and one bank
interface stripe_rd_if;
  import stripe_pkg::*;

  logic [ROW_BITS-1:0]   araddr;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_WIDTH-1:0] rdata;
  logic [RESP_WIDTH-1:0] rresp;
  logic                  rvalid;
  logic                  rready;

  modport router (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport bank (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

  modport mon (
    input araddr, arvalid, arready, rdata, rresp, rvalid, rready
  );

endinterface

//--- source/axi_stripe_router.sv
module axi_stripe_router (
  input  logic                            axi_clk,
  input  logic                            arst_n,
  input  logic                            avalid,
  input  logic [stripe_pkg::ADDR_WIDTH-1:0] addr,
  input  logic                            req_accepted,
  input  logic                            resp_accepted,
  output logic [stripe_pkg::SEL_BITS-1:0]   req_sel,
  output logic                            req_active,
  output logic [stripe_pkg::SEL_BITS-1:0]   resp_sel,
  output logic                            resp_active
);
  import stripe_pkg::*;

  logic [SEL_BITS-1:0] addr_sel;

  // Registered owners of the request and response phases
  logic [SEL_BITS-1:0] req_sel_q;
  logic                req_active_q;
  logic [SEL_BITS-1:0] resp_sel_q;
  logic                resp_active_q;

  // Bank field sits just above the byte offset
  assign addr_sel = addr[BYTE_BITS +: SEL_BITS];

  // A new request is only claimed when no response is pending, so one
  // transaction per direction is in flight at most
  assign req_active = req_active_q || (avalid && !resp_active_q);
  assign req_sel    = req_active_q ? req_sel_q : addr_sel;

  assign resp_active = resp_active_q;
  assign resp_sel    = resp_sel_q;

  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      req_active_q  <= 1'b0;
      req_sel_q     <= '0;
      resp_active_q <= 1'b0;
      resp_sel_q    <= '0;
    end else begin
      if (req_accepted) begin
        // Hand the owning bank over to the response phase
        req_active_q  <= 1'b0;
        resp_active_q <= 1'b1;
        resp_sel_q    <= req_sel;
      end else begin
        if (req_active && !req_active_q) begin
          req_active_q <= 1'b1;
          req_sel_q    <= req_sel;
        end
        if (resp_accepted) begin
          resp_active_q <= 1'b0;
        end
      end
    end
  end

endmodule

//--- source/axi_stripe_writer.sv
module axi_stripe_writer (
  input  logic                              axi_clk,
  input  logic                              arst_n,
  input  logic [stripe_pkg::ADDR_WIDTH-1:0] awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [stripe_pkg::DATA_WIDTH-1:0] wdata,
  input  logic [stripe_pkg::STRB_WIDTH-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [stripe_pkg::RESP_WIDTH-1:0] bresp,
  output logic                              bvalid,
  input  logic                              bready,
  stripe_wr_if.router                       banks [stripe_pkg::NUM_BANKS]
);
  import stripe_pkg::*;

  logic [SEL_BITS-1:0]   req_sel;
  logic                  req_active;
  logic [SEL_BITS-1:0]   resp_sel;
  logic                  resp_active;

  logic                  aw_hs;
  logic                  w_hs;
  logic                  awdone;
  logic                  wdone;
  logic                  req_accepted;
  logic                  resp_accepted;

  // Per-bank return signals gathered so they can be indexed
  logic [NUM_BANKS-1:0]  bank_awready;
  logic [NUM_BANKS-1:0]  bank_wready;
  logic [NUM_BANKS-1:0]  bank_bvalid;
  logic [RESP_WIDTH-1:0] bank_bresp [NUM_BANKS];

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  // The pair completes on whichever handshake comes last
  assign req_accepted  = (awdone || aw_hs) && (wdone || w_hs);
  assign resp_accepted = bvalid && bready;

  axi_stripe_router u_router (
    .axi_clk      (axi_clk),
    .arst_n       (arst_n),
    .avalid       (awvalid),
    .addr         (awaddr),
    .req_accepted (req_accepted),
    .resp_accepted(resp_accepted),
    .req_sel      (req_sel),
    .req_active   (req_active),
    .resp_sel     (resp_sel),
    .resp_active  (resp_active)
  );

  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      awdone <= 1'b0;
      wdone  <= 1'b0;
    end else if (req_accepted) begin
      awdone <= 1'b0;
      wdone  <= 1'b0;
    end else begin
      if (aw_hs) awdone <= 1'b1;
      if (w_hs)  wdone  <= 1'b1;
    end
  end

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    // Payload goes to every bank, only the owner sees valid
    assign banks[i].awaddr  = awaddr[ADDR_WIDTH-1:BYTE_BITS+SEL_BITS];
    assign banks[i].awvalid = req_active && (req_sel == SEL_BITS'(i)) && awvalid && !awdone;
    assign banks[i].wdata   = wdata;
    assign banks[i].wstrb   = wstrb;
    assign banks[i].wvalid  = req_active && (req_sel == SEL_BITS'(i)) && wvalid && !wdone;
    assign banks[i].bready  = resp_active && (resp_sel == SEL_BITS'(i)) && bready;

    assign bank_awready[i] = banks[i].awready;
    assign bank_wready[i]  = banks[i].wready;
    assign bank_bvalid[i]  = banks[i].bvalid;
    assign bank_bresp[i]   = banks[i].bresp;
  end

  // A channel stays closed once its own handshake is done
  assign awready = req_active && bank_awready[req_sel] && !awdone;
  assign wready  = req_active && bank_wready[req_sel] && !wdone;

  assign bvalid = resp_active && bank_bvalid[resp_sel];
  assign bresp  = resp_active ? bank_bresp[resp_sel] : RESP_OKAY;

endmodule

//--- source/axi_stripe_reader.sv
module axi_stripe_reader (
  input  logic                              axi_clk,
  input  logic                              arst_n,
  input  logic [stripe_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [stripe_pkg::DATA_WIDTH-1:0] rdata,
  output logic [stripe_pkg::RESP_WIDTH-1:0] rresp,
  output logic                              rvalid,
  input  logic                              rready,
  stripe_rd_if.router                       banks [stripe_pkg::NUM_BANKS]
);
  import stripe_pkg::*;

  logic [SEL_BITS-1:0]   req_sel;
  logic                  req_active;
  logic [SEL_BITS-1:0]   resp_sel;
  logic                  resp_active;
  logic                  req_accepted;
  logic                  resp_accepted;

  logic [NUM_BANKS-1:0]  bank_arready;
  logic [NUM_BANKS-1:0]  bank_rvalid;
  logic [DATA_WIDTH-1:0] bank_rdata [NUM_BANKS];
  logic [RESP_WIDTH-1:0] bank_rresp [NUM_BANKS];

  // A read needs only the AR handshake to move to its response phase
  assign req_accepted  = arvalid && arready;
  assign resp_accepted = rvalid && rready;

  axi_stripe_router u_router (
    .axi_clk      (axi_clk),
    .arst_n       (arst_n),
    .avalid       (arvalid),
    .addr         (araddr),
    .req_accepted (req_accepted),
    .resp_accepted(resp_accepted),
    .req_sel      (req_sel),
    .req_active   (req_active),
    .resp_sel     (resp_sel),
    .resp_active  (resp_active)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    assign banks[i].araddr  = araddr[ADDR_WIDTH-1:BYTE_BITS+SEL_BITS];
    assign banks[i].arvalid = req_active && (req_sel == SEL_BITS'(i)) && arvalid;
    assign banks[i].rready  = resp_active && (resp_sel == SEL_BITS'(i)) && rready;

    assign bank_arready[i] = banks[i].arready;
    assign bank_rvalid[i]  = banks[i].rvalid;
    assign bank_rdata[i]   = banks[i].rdata;
    assign bank_rresp[i]   = banks[i].rresp;
  end

  assign arready = req_active && bank_arready[req_sel];

  // Response side follows the bank that took the last AR
  assign rvalid = resp_active && bank_rvalid[resp_sel];
  assign rdata  = resp_active ? bank_rdata[resp_sel] : '0;
  assign rresp  = resp_active ? bank_rresp[resp_sel] : RESP_OKAY;

endmodule

//--- source/stripe_bank.sv
module stripe_bank (
  input logic       axi_clk,
  input logic       arst_n,
  stripe_wr_if.bank wr,
  stripe_rd_if.bank rd
);
  import stripe_pkg::*;

  logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];

  // Readies come up one cycle after reset is released
  logic                  ready_en;

  logic                  aw_hs;
  logic                  w_hs;
  logic                  aw_done;
  logic                  w_done;
  logic                  wr_fire;
  logic                  bvalid_q;

  // Captured write payload for split AW and W handshakes
  logic [ROW_BITS-1:0]   row_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic [STRB_WIDTH-1:0] strb_q;
  logic [ROW_BITS-1:0]   wr_row;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;

  logic                  ar_hs;
  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_q;

  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n) ready_en <= 1'b0;
    else         ready_en <= 1'b1;
  end

  // Write port
  assign wr.awready = ready_en && !bvalid_q && !aw_done;
  assign wr.wready  = ready_en && !bvalid_q && !w_done;
  assign wr.bvalid  = bvalid_q;
  assign wr.bresp   = RESP_OKAY;

  assign aw_hs   = wr.awvalid && wr.awready;
  assign w_hs    = wr.wvalid && wr.wready;
  assign wr_fire = (aw_done || aw_hs) && (w_done || w_hs);

  // Use the live payload when its handshake is happening right now
  assign wr_row  = aw_done ? row_q : wr.awaddr;
  assign wr_data = w_done ? data_q : wr.wdata;
  assign wr_strb = w_done ? strb_q : wr.wstrb;

  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        aw_done  <= 1'b0;
        w_done   <= 1'b0;
        bvalid_q <= 1'b1;
      end else begin
        if (aw_hs)                aw_done  <= 1'b1;
        if (w_hs)                 w_done   <= 1'b1;
        if (bvalid_q && wr.bready) bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (aw_hs) row_q <= wr.awaddr;
    if (w_hs) begin
      data_q <= wr.wdata;
      strb_q <= wr.wstrb;
    end
    if (wr_fire) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (wr_strb[b]) mem[wr_row][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

  // The read port samples the row on the AR transfer and holds it until taken
  assign rd.arready = ready_en && !rvalid_q;
  assign rd.rvalid  = rvalid_q;
  assign rd.rdata   = rdata_q;
  assign rd.rresp   = RESP_OKAY;

  assign ar_hs = rd.arvalid && rd.arready;

  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n)                     rvalid_q <= 1'b0;
    else if (ar_hs)                  rvalid_q <= 1'b1;
    else if (rvalid_q && rd.rready)  rvalid_q <= 1'b0;
  end

  always_ff @(posedge axi_clk) begin
    if (ar_hs) rdata_q <= mem[rd.araddr];
  end

endmodule

//--- source/axi_stripe_mem.sv
module axi_stripe_mem (
  input  logic                              axi_clk,
  input  logic                              arst_n,
  input  logic [stripe_pkg::ADDR_WIDTH-1:0] awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [stripe_pkg::DATA_WIDTH-1:0] wdata,
  input  logic [stripe_pkg::STRB_WIDTH-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [stripe_pkg::RESP_WIDTH-1:0] bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [stripe_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [stripe_pkg::DATA_WIDTH-1:0] rdata,
  output logic [stripe_pkg::RESP_WIDTH-1:0] rresp,
  output logic                              rvalid,
  input  logic                              rready
);
  import stripe_pkg::*;

  // One write path and one read path per bank
  stripe_wr_if wr_bus [NUM_BANKS] ();
  stripe_rd_if rd_bus [NUM_BANKS] ();

  axi_stripe_writer u_writer (
    .axi_clk(axi_clk), .arst_n(arst_n),
    .awaddr (awaddr),  .awvalid(awvalid), .awready(awready),
    .wdata  (wdata),   .wstrb  (wstrb),   .wvalid (wvalid), .wready(wready),
    .bresp  (bresp),   .bvalid (bvalid),  .bready (bready),
    .banks  (wr_bus)
  );

  axi_stripe_reader u_reader (
    .axi_clk(axi_clk), .arst_n(arst_n),
    .araddr (araddr),  .arvalid(arvalid), .arready(arready),
    .rdata  (rdata),   .rresp  (rresp),   .rvalid (rvalid), .rready(rready),
    .banks  (rd_bus)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    stripe_bank u_bank (
      .axi_clk(axi_clk),
      .arst_n (arst_n),
      .wr     (wr_bus[i]),
      .rd     (rd_bus[i])
    );
  end

endmodule

//--- bench/axi_stripe_mem_asserts.sv
module axi_stripe_mem_asserts (
  input logic                              axi_clk,
  input logic                              arst_n,
  input logic                              awready,
  input logic [stripe_pkg::RESP_WIDTH-1:0] bresp,
  input logic                              bvalid,
  input logic                              bready,
  input logic                              arready,
  input logic [stripe_pkg::DATA_WIDTH-1:0] rdata,
  input logic                              rvalid,
  input logic                              rready
);

  // Number of property failures seen so far
  int fail_count = 0;

  // A pending B response is held until it is taken
  a_b_hold: assert property (@(posedge axi_clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      fail_count++;
      $error("bvalid or bresp changed while bready was low");
    end

  // Same rule for the read data channel
  a_r_hold: assert property (@(posedge axi_clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      fail_count++;
      $error("rvalid or rdata changed while rready was low");
    end

  a_aw_closed: assert property (@(posedge axi_clk) disable iff (!arst_n)
    bvalid |-> !awready)
    else begin
      fail_count++;
      $error("awready was high while a B response was pending");
    end

  a_ar_closed: assert property (@(posedge axi_clk) disable iff (!arst_n)
    rvalid |-> !arready)
    else begin
      fail_count++;
      $error("arready was high while an R response was pending");
    end

endmodule

bind axi_stripe_mem axi_stripe_mem_asserts u_asserts (.*);

//--- bench/axi_stripe_mem_tb.sv
module axi_stripe_mem_tb;
  import stripe_pkg::*;

  logic                  axi_clk;
  logic                  arst_n;
  logic [ADDR_WIDTH-1:0] awaddr, araddr;
  logic [DATA_WIDTH-1:0] wdata, rdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic [RESP_WIDTH-1:0] bresp, rresp;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready;

  // Expected contents, one entry per word address
  logic [DATA_WIDTH-1:0] model [2**(ADDR_WIDTH-BYTE_BITS)];
  logic [31:0]           rng_state;

  axi_stripe_mem u_axi_stripe_mem (.*);

  initial axi_clk = 1'b0;
  always #10 axi_clk = ~axi_clk;

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Bytes with their strobe bit set take the new data
  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
      input logic [DATA_WIDTH-1:0] new_word, input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  function automatic logic handshake_level(input string name);
    case (name)
      "awready": return awready;
      "wready":  return wready;
      "arready": return arready;
      default:   return 1'bx;
    endcase
  endfunction

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
      stop_with_failure();
    end
  endtask

  // A failed port assertion ends the run at the next falling edge
  always @(negedge axi_clk) begin
    if (u_axi_stripe_mem.u_asserts.fail_count != 0) begin
      $display("A protocol assertion on the DUT ports failed");
      stop_with_failure();
    end
  end

  // Returns just after a falling edge with the named ready high
  task automatic wait_for_high(input string name);
    int cycles;
    cycles = 0;
    #1;
    while (handshake_level(name) !== 1'b1) begin
      cycles++;
      if (cycles > 50) begin
        $display("Timeout while waiting for %s to go high", name);
        stop_with_failure();
      end
      @(negedge axi_clk);
      #1;
    end
  endtask

  task automatic check_quiet();
    check_value("bvalid", bvalid, 1'b0);
    check_value("rvalid", rvalid, 1'b0);
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("arready", arready, 1'b0);
  endtask

  // bvalid must already be up one edge after the last request handshake
  task automatic take_write_response();
    check_value("bvalid", bvalid, 1'b1);
    check_value("bresp", bresp, RESP_OKAY);
    bready = 1'b1;
    @(negedge axi_clk);
    bready = 1'b0;
    check_value("bvalid", bvalid, 1'b0);
  endtask

  task automatic take_read_response(input logic [DATA_WIDTH-1:0] expected);
    check_value("rvalid", rvalid, 1'b1);
    check_value("rdata", rdata, expected);
    check_value("rresp", rresp, RESP_OKAY);
    rready = 1'b1;
    @(negedge axi_clk);
    rready = 1'b0;
    check_value("rvalid", rvalid, 1'b0);
  endtask

  // Order 0 offers AW and W together, 1 sends AW first, 2 offers W ahead of AW
  task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                            input logic [STRB_WIDTH-1:0] strb, input int order);
    awaddr = addr;
    wdata  = data;
    wstrb  = strb;
    if (order == 1) begin
      awvalid = 1'b1;
      wait_for_high("awready");
      @(negedge axi_clk);
      awvalid = 1'b0;
      check_value("bvalid", bvalid, 1'b0);
      @(negedge axi_clk);
    end else if (order == 2) begin
      wvalid = 1'b1;
      repeat (2) @(negedge axi_clk);
    end
    awvalid = (order != 1);
    wvalid  = 1'b1;
    wait_for_high("wready");
    if (order != 1) check_value("awready", awready, 1'b1);
    @(negedge axi_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    model[addr >> BYTE_BITS] = merge_bytes(model[addr >> BYTE_BITS], data, strb);
    take_write_response();
  endtask

  task automatic read_word(input logic [ADDR_WIDTH-1:0] addr);
    araddr  = addr;
    arvalid = 1'b1;
    wait_for_high("arready");
    @(negedge axi_clk);
    arvalid = 1'b0;
    take_read_response(model[addr >> BYTE_BITS]);
  endtask

  task automatic test_reset();
    repeat (3) begin
      @(negedge axi_clk);
      check_quiet();
    end
    // A write is offered at release but the readies wait for the next edge
    awaddr  = 10'h000;
    wdata   = 16'h0f0f;
    wstrb   = '1;
    arst_n  = 1'b1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    check_quiet();
    @(negedge axi_clk);
    #1;
    check_value("awready", awready, 1'b1);
    check_value("wready", wready, 1'b1);
    @(negedge axi_clk);
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    model[0] = 16'h0f0f;
    take_write_response();
    read_word(10'h000);
  endtask

  task automatic test_striping();
    for (int w = 0; w < 16; w++) begin
      write_word(ADDR_WIDTH'(w << BYTE_BITS), DATA_WIDTH'(next_random()), '1, 0);
    end
    for (int w = 0; w < 16; w++) begin
      read_word(ADDR_WIDTH'(w << BYTE_BITS));
    end
  endtask

  task automatic test_strobes();
    write_word(10'h006, 16'ha5c3, 2'b01, 1);
    write_word(10'h007, 16'h5a3c, 2'b10, 2);
    write_word(10'h00a, 16'hbeef, 2'b10, 2);
    write_word(10'h00c, 16'hcafe, 2'b01, 1);
    read_word(10'h006);
    read_word(10'h00a);
    read_word(10'h00c);
  endtask

  task automatic test_backpressure();
    awaddr  = 10'h010;
    wdata   = 16'h1111;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_for_high("awready");
    @(negedge axi_clk);
    model[8] = 16'h1111;
    // The next write stays offered while the B response is refused
    awaddr = 10'h012;
    wdata  = 16'h2222;
    repeat (5) begin
      @(negedge axi_clk);
      #1;
      check_value("bvalid", bvalid, 1'b1);
      check_value("bresp", bresp, RESP_OKAY);
      check_value("awready", awready, 1'b0);
      check_value("wready", wready, 1'b0);
    end
    @(negedge axi_clk);
    take_write_response();
    write_word(10'h012, 16'h2222, '1, 0);

    araddr  = 10'h010;
    arvalid = 1'b1;
    wait_for_high("arready");
    @(negedge axi_clk);
    araddr = 10'h012;
    repeat (5) begin
      @(negedge axi_clk);
      #1;
      check_value("rvalid", rvalid, 1'b1);
      check_value("rdata", rdata, model[8]);
      check_value("arready", arready, 1'b0);
    end
    @(negedge axi_clk);
    take_read_response(model[8]);
    read_word(10'h012);
  endtask

  task automatic test_traffic();
    logic [31:0]           r;
    logic [ADDR_WIDTH-1:0] addr;
    // Bank 0 read and bank 1 write start on the same edge
    araddr  = 10'h000;
    arvalid = 1'b1;
    awaddr  = 10'h002;
    wdata   = 16'h7e81;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_for_high("awready");
    check_value("arready", arready, 1'b1);
    check_value("wready", wready, 1'b1);
    @(negedge axi_clk);
    arvalid  = 1'b0;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    model[1] = 16'h7e81;
    take_read_response(model[0]);
    take_write_response();
    for (int n = 0; n < 200; n++) begin
      r    = next_random();
      addr = ADDR_WIDTH'(r[3:0]) << BYTE_BITS;
      if (r[8]) write_word(addr, r[31:16], r[5:4], int'(r[7:6]) % 3);
      else read_word(addr);
    end
  endtask

  initial begin
    rng_state = 32'd9;
    arst_n    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    test_reset();
    test_striping();
    test_strobes();
    test_backpressure();
    test_traffic();
    if (u_axi_stripe_mem.u_asserts.fail_count != 0) begin
      $display("Assertion failures seen: %0d", u_axi_stripe_mem.u_asserts.fail_count);
      stop_with_failure();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- vlog.f
source/stripe_pkg.sv
source/stripe_if.sv
source/axi_stripe_router.sv
source/axi_stripe_writer.sv
source/axi_stripe_reader.sv
source/stripe_bank.sv
source/axi_stripe_mem.sv
bench/axi_stripe_mem_asserts.sv
bench/axi_stripe_mem_tb.sv
